// File: Bender.yml
package:
  name: vga_overlay

sources:
  - include_dirs:
      - source
    files:
      - source/overlay_pkg.sv
      - source/text_window.sv
      - source/title_strokes.sv
      - source/overlay_pixel_stage.sv
      - source/vga_overlay_top.sv
  - target: test
    files:
      - bench/tb_vga_overlay.sv

// File: all.f
+incdir+source
source/overlay_pkg.sv
source/text_window.sv
source/title_strokes.sv
source/overlay_pixel_stage.sv
source/vga_overlay_top.sv
bench/tb_vga_overlay.sv

// File: bench/overlay_stimulus.txt
# start choice hcount vcount hsync vsync hblnk vblnk char_pixels | expected char_xy char_line rgb
# all fields hex, one pixel per line
0 0 1ea 258 0 0 0 0 80 00 0 333
0 0 1ed 25b 1 0 0 0 ef 00 3 eee
0 0 211 266 0 1 0 0 01 04 e 333
0 0 1f2 262 0 0 1 0 7f 01 a eee
0 0 212 258 0 0 0 1 ff 05 0 888
0 0 1ea 267 1 1 0 0 ff 00 f 888
0 0 1e9 25d 0 0 1 1 ff 0f 5 888
0 0 082 0c8 1 0 1 0 00 73 0 f00
0 0 0c8 0c8 0 1 0 1 00 7b 0 f00
0 0 0c9 0c8 1 1 1 1 00 7b 0 888
0 0 0a5 0fa 0 0 0 0 00 a7 2 f00
0 0 0a6 0fa 1 0 0 1 00 a7 2 888
0 0 0a5 12c 0 1 1 0 00 d7 4 f00
0 0 064 17c 1 0 0 0 00 2f 4 f00
0 0 064 17d 0 0 1 0 00 2f 5 888
0 0 1db 0fa 1 1 0 0 00 ae 2 f00
0 0 1db 0fb 0 0 0 1 00 ae 3 888
1 1 1d6 12c 1 0 0 0 80 00 0 333
1 1 243 13a 0 1 0 0 fb 0d e eee
1 1 209 134 0 0 1 0 10 06 8 333
1 1 244 12c 0 0 0 1 ff 0d 0 888
1 1 12c 1c2 1 1 0 0 00 9a 6 00f
1 1 190 226 0 0 1 1 00 f7 a 00f
1 1 191 226 1 0 1 0 00 f7 a 888
1 1 12b 1c2 0 1 0 1 00 9a 6 888
1 1 28a 1c2 1 1 1 1 00 96 6 ff0
1 1 2ee 226 0 0 0 0 00 f3 a ff0
1 1 2ee 227 1 0 0 1 00 f3 b 888
1 1 28a 1c1 0 1 1 0 00 96 5 888
1 1 082 0c8 1 0 0 0 00 95 c 888
1 1 1ea 258 0 0 1 0 ff 22 c 888
1 0 1ea 258 1 1 0 0 ff 00 0 888
1 0 1d6 12c 0 0 0 1 80 dd 4 888
1 0 12c 1c2 1 0 1 1 00 68 a 888
1 0 082 0c8 0 1 0 0 00 73 0 888
1 0 28a 226 1 1 1 0 00 c4 e 888

// File: bench/tb_vga_overlay.sv
`timescale 1ns/1ps

module tb_vga_overlay
    import overlay_pkg::*;
;

    //////////////////////////////////////////////////
    // dut signals
    //////////////////////////////////////////////////

    logic         pclk;
    logic         rst;
    pixel_coord_t hcount_in;
    pixel_coord_t vcount_in;
    logic         hsync_in;
    logic         vsync_in;
    logic         hblnk_in;
    logic         vblnk_in;
    logic         start_en;
    logic         choice_en;
    logic [7:0]   char_pixels;    // stands in for the char rom
    pixel_coord_t hcount_out;
    pixel_coord_t vcount_out;
    logic         hsync_out;
    logic         vsync_out;
    logic         hblnk_out;
    logic         vblnk_out;
    rgb12_t       rgb_out;
    logic [7:0]   char_xy;
    logic [3:0]   char_line;

    // one queue per column of the stimulus file
    logic         vec_start[$];
    logic         vec_choice[$];
    pixel_coord_t vec_h[$];
    pixel_coord_t vec_v[$];
    logic [3:0]   vec_sync[$];    // hsync vsync hblnk vblnk
    logic [7:0]   vec_pixels[$];
    logic [7:0]   exp_xy[$];
    logic [3:0]   exp_line[$];
    logic [11:0]  exp_rgb[$];

    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 20;         // raised once vectors are loaded

    vga_overlay_top DUT (.*);

    always #4 pclk = ~pclk;       // 8 ns pixel clock

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    always @(posedge pclk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles, vector loop did not finish", cycle_count);
            $display("sim failed");
            $fatal(1, "run stopped by watchdog");
        end
    end

    // stop at first mismatch
    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, input int idx);
        assert (got === exp)
        else
        begin
            error_count++;
            $display("CHECK FAILED %s (vector %0d): got 0x%0h expected 0x%0h",
                     name, idx, got, exp);
            $display("sim failed");
            $fatal(1, "first mismatch");
        end
    endtask

    // fill the queues, skip comment and blank lines
    task automatic load_vectors;
        int          fd;
        int          n;
        string       line;
        logic [31:0] s, c, h, v, hs, vs, hb, vb, px, xy, ln, rgb;
        fd = $fopen("bench/overlay_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/overlay_stimulus.txt");
            $display("sim failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            if ((line.len() == 0) || (line[0] == "#"))
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        s, c, h, v, hs, vs, hb, vb, px, xy, ln, rgb);
            if (n == 12)
            begin
                vec_start.push_back(s[0]);
                vec_choice.push_back(c[0]);
                vec_h.push_back(h[10:0]);
                vec_v.push_back(v[10:0]);
                vec_sync.push_back({hs[0], vs[0], hb[0], vb[0]});
                vec_pixels.push_back(px[7:0]);
                exp_xy.push_back(xy[7:0]);
                exp_line.push_back(ln[3:0]);
                exp_rgb.push_back(rgb[11:0]);
            end
            else if (n > 0)
            begin
                $display("malformed stimulus line: %s", line);
                $display("sim failed");
                $fatal(1, "bad stimulus file");
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input int i);
        start_en    = vec_start[i];
        choice_en   = vec_choice[i];
        hcount_in   = vec_h[i];
        vcount_in   = vec_v[i];
        {hsync_in, vsync_in, hblnk_in, vblnk_in} = vec_sync[i];
        char_pixels = vec_pixels[i];
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        pclk        = 1'b0;
        rst         = 1'b1;
        hcount_in   = 11'd490;    // non-zero inputs while reset is held
        vcount_in   = 11'd600;
        hsync_in    = 1'b1;
        vsync_in    = 1'b1;
        hblnk_in    = 1'b1;
        vblnk_in    = 1'b1;
        start_en    = 1'b0;
        choice_en   = 1'b0;
        char_pixels = 8'hff;

        load_vectors();
        cycle_limit = vec_h.size() + 20;
        $display("loaded %0d vectors", vec_h.size());

        repeat (2) @(posedge pclk);   // reset held two cycles
        @(negedge pclk);
        rst = 1'b0;

        // registered outputs still cleared
        compare("hcount_out", hcount_out, 0, -1);
        compare("vcount_out", vcount_out, 0, -1);
        compare("syncs_blanks", {hsync_out, vsync_out, hblnk_out, vblnk_out}, 0, -1);
        compare("rgb_out", rgb_out, 0, -1);

        for (int i = 0; i < vec_h.size(); i++)
        begin
            apply_vector(i);
            #1;
            compare("char_xy", char_xy, exp_xy[i], i);     // rom address, zero latency
            compare("char_line", char_line, exp_line[i], i);
            @(negedge pclk);                               // one rising edge later
            compare("hcount_out", hcount_out, vec_h[i], i);
            compare("vcount_out", vcount_out, vec_v[i], i);
            compare("hsync_out", hsync_out, vec_sync[i][3], i);
            compare("vsync_out", vsync_out, vec_sync[i][2], i);
            compare("hblnk_out", hblnk_out, vec_sync[i][1], i);
            compare("vblnk_out", vblnk_out, vec_sync[i][0], i);
            compare("rgb_out", rgb_out, exp_rgb[i], i);
        end

        if (error_count == 0)
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            $display("sim failed");
            $fatal(1, "%0d mismatches", error_count);
        end
    end

endmodule

// File: source/overlay_macros.svh
`ifndef OVERLAY_MACROS_SVH
`define OVERLAY_MACROS_SVH

//////////////////////////////////////////////////
// colours, 4 bits per channel r g b
//////////////////////////////////////////////////

`define OVL_LETTER_RGB    12'h333   // glyph foreground
`define OVL_TEXT_BG_RGB   12'heee   // text box fill
`define OVL_STROKE_RGB    12'hf00   // red title lettering
`define OVL_FIELD_RGB     12'h888   // grey background
`define OVL_BLUE_RGB      12'h00f
`define OVL_YELLOW_RGB    12'hff0

//////////////////////////////////////////////////
// text boxes
//////////////////////////////////////////////////

// title screen box, top left corner
`define OVL_TITLE_BOX_X   11'd490
`define OVL_TITLE_BOX_Y   11'd600
`define OVL_TITLE_BOX_W   11'd40

// choice screen box
`define OVL_CHOICE_BOX_X  11'd470
`define OVL_CHOICE_BOX_Y  11'd300
`define OVL_CHOICE_BOX_W  11'd110

`define OVL_BOX_H         11'd15    // both boxes, one glyph row

//////////////////////////////////////////////////
// choice panels, edges inclusive
//////////////////////////////////////////////////

`define OVL_PANEL_TOP     11'd450
`define OVL_PANEL_BOTTOM  11'd550
`define OVL_BLUE_LEFT     11'd300
`define OVL_YELLOW_LEFT   11'd650
`define OVL_PANEL_SIZE    11'd100   // right edge = left + size

//////////////////////////////////////////////////
// title lettering
//////////////////////////////////////////////////

`define OVL_TITLE_OFS     11'd100   // added to x and y of title strokes
`define OVL_ROW_TOP       11'd100   // letter top, before offset
`define OVL_ROW_MID       11'd150   // crossbar of A and E
`define OVL_ROW_BOT       11'd200   // letter baseline

`endif

// File: source/overlay_pixel_stage.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module overlay_pixel_stage
    import overlay_pkg::*;
(
    input  logic         pclk,
    input  logic         rst,
    input  pixel_coord_t hcount_in,
    input  pixel_coord_t vcount_in,
    input  logic         hsync_in,
    input  logic         vsync_in,
    input  logic         hblnk_in,
    input  logic         vblnk_in,
    input  screen_mode_t screen_mode,
    input  logic         text_hit,     // already gated by mode
    input  logic         glyph_on,
    input  logic         stroke_hit,
    output pixel_coord_t hcount_out,
    output pixel_coord_t vcount_out,
    output logic         hsync_out,
    output logic         vsync_out,
    output logic         hblnk_out,
    output logic         vblnk_out,
    output rgb12_t       rgb_out
);

    logic   in_rows;
    logic   blue_hit;
    logic   yellow_hit;
    rgb12_t rgb_nxt;

    //////////////////////////////////////////////////
    // choice panels
    //////////////////////////////////////////////////

    assign in_rows = (vcount_in >= `OVL_PANEL_TOP) && (vcount_in <= `OVL_PANEL_BOTTOM);

    assign blue_hit = (screen_mode == MODE_CHOICE) && in_rows &&
                      (hcount_in >= `OVL_BLUE_LEFT) &&
                      (hcount_in <= `OVL_BLUE_LEFT + `OVL_PANEL_SIZE);

    assign yellow_hit = (screen_mode == MODE_CHOICE) && in_rows &&
                        (hcount_in >= `OVL_YELLOW_LEFT) &&
                        (hcount_in <= `OVL_YELLOW_LEFT + `OVL_PANEL_SIZE);

    // colour priority, text over strokes over panels over field
    always_comb
    begin
        if (text_hit)
            rgb_nxt = glyph_on ? `OVL_LETTER_RGB : `OVL_TEXT_BG_RGB;
        else if (stroke_hit && (screen_mode == MODE_TITLE))
            rgb_nxt = `OVL_STROKE_RGB;
        else if (blue_hit)
            rgb_nxt = `OVL_BLUE_RGB;
        else if (yellow_hit)
            rgb_nxt = `OVL_YELLOW_RGB;
        else
            rgb_nxt = `OVL_FIELD_RGB;
    end

    //////////////////////////////////////////////////
    // output register, one pixel of delay
    //////////////////////////////////////////////////

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end
        else
        begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= rgb_nxt;   // colour aligned with its timing
        end
    end

    // mode from the window decoder is one of the three screens
    assert property (@(posedge pclk) disable iff (rst)
        screen_mode inside {MODE_TITLE, MODE_CHOICE, MODE_BLANK})
    else $error("screen_mode has no legal encoding");

    // text box never reported on the blank screen
    assert property (@(posedge pclk) disable iff (rst)
        text_hit |-> (screen_mode != MODE_BLANK))
    else $error("text_hit set while screen is blank");

endmodule

// File: source/overlay_pkg.sv
package overlay_pkg;

    // raster coordinate, wide enough for 1024+ counters
    typedef logic [10:0] pixel_coord_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    // what the overlay paints this frame
    typedef enum logic [1:0] {
        MODE_TITLE  = 2'd0,
        MODE_CHOICE = 2'd1,
        MODE_BLANK  = 2'd2
    } screen_mode_t;

    // one straight stroke of the title lettering
    typedef struct packed {
        logic         vert;   // 1 = vertical, fixed is the column
        pixel_coord_t fixed;  // row or column the stroke sits on
        pixel_coord_t first;  // inclusive start along the stroke
        pixel_coord_t last;   // inclusive end
    } stroke_t;

endpackage

// File: source/text_window.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module text_window
    import overlay_pkg::*;
(
    input  pixel_coord_t hcount,
    input  pixel_coord_t vcount,
    input  logic         start_en,
    input  logic         choice_en,
    input  logic [7:0]   char_pixels,  // glyph row from char rom
    output screen_mode_t screen_mode,
    output logic         text_hit,
    output logic         glyph_on,
    output logic [7:0]   char_xy,
    output logic [3:0]   char_line
);

    pixel_coord_t box_x;
    pixel_coord_t box_y;
    pixel_coord_t box_w;
    pixel_coord_t rel_x;
    pixel_coord_t rel_y;
    logic         in_box;

    //////////////////////////////////////////////////
    // screen mode
    //////////////////////////////////////////////////

    always_comb
    begin
        if (!start_en)
            screen_mode = MODE_TITLE;      // game not started yet
        else if (choice_en)
            screen_mode = MODE_CHOICE;     // player picks colour
        else
            screen_mode = MODE_BLANK;
    end

    // box origin follows the mode, title box otherwise
    always_comb
    begin
        if (screen_mode == MODE_CHOICE)
        begin
            box_x = `OVL_CHOICE_BOX_X;
            box_y = `OVL_CHOICE_BOX_Y;
            box_w = `OVL_CHOICE_BOX_W;
        end
        else
        begin
            box_x = `OVL_TITLE_BOX_X;
            box_y = `OVL_TITLE_BOX_Y;
            box_w = `OVL_TITLE_BOX_W;
        end
    end

    //////////////////////////////////////////////////
    // box hit test and rom addressing
    //////////////////////////////////////////////////

    assign rel_x = hcount - box_x;  // wraps outside the box, harmless
    assign rel_y = vcount - box_y;

    assign in_box = (hcount >= box_x) && (hcount < box_x + box_w) &&
                    (vcount >= box_y) && (vcount < box_y + `OVL_BOX_H);

    assign text_hit = in_box && (screen_mode != MODE_BLANK);

    // upper nibble = text row, lower nibble = char column (8 px glyphs)
    assign char_xy   = {rel_y[7:4], rel_x[6:3]};
    assign char_line = rel_y[3:0];  // line within glyph

    // msb is the leftmost pixel of the glyph
    assign glyph_on = char_pixels[3'd7 - rel_x[2:0]];

endmodule

// File: source/title_strokes.sv
`timescale 1ns/1ps
`include "overlay_macros.svh"

module title_strokes
    import overlay_pkg::*;
(
    input  pixel_coord_t hcount,
    input  pixel_coord_t vcount,
    output logic         stroke_hit
);

    localparam logic V = 1'b1;  // vertical stroke
    localparam logic H = 1'b0;  // horizontal stroke
    localparam int N_STROKES = 60;

    // absolute stroke
    function automatic stroke_t seg(input logic vert, input int fix, input int first,
                                    input int last);
        stroke_t s;
        s.vert  = vert;
        s.fixed = pixel_coord_t'(fix);
        s.first = pixel_coord_t'(first);
        s.last  = pixel_coord_t'(last);
        return s;
    endfunction

    // title stroke, shifted right and down by the title offset
    function automatic stroke_t tseg(input logic vert, input int fix, input int first,
                                     input int last);
        return seg(vert, fix + `OVL_TITLE_OFS, first + `OVL_TITLE_OFS,
                   last + `OVL_TITLE_OFS);
    endfunction

    //////////////////////////////////////////////////
    // stroke table
    //////////////////////////////////////////////////

    localparam stroke_t STROKES [N_STROKES] = '{
        // title, T I C
        tseg(H, `OVL_ROW_TOP, 30, 100),
        tseg(V, 65, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(V, 120, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(V, 140, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(H, `OVL_ROW_TOP, 140, 210),
        tseg(H, `OVL_ROW_BOT, 140, 210),
        // T A C
        tseg(H, `OVL_ROW_TOP, 250, 320),
        tseg(V, 285, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(V, 340, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(V, 410, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(H, `OVL_ROW_TOP, 340, 410),
        tseg(H, `OVL_ROW_MID, 340, 410),    // A crossbar
        tseg(H, `OVL_ROW_TOP, 430, 500),
        tseg(H, `OVL_ROW_BOT, 430, 500),
        tseg(V, 430, `OVL_ROW_TOP, `OVL_ROW_BOT),
        // T O E
        tseg(H, `OVL_ROW_TOP, 540, 610),
        tseg(V, 575, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(H, `OVL_ROW_TOP, 630, 700),
        tseg(H, `OVL_ROW_BOT, 630, 700),
        tseg(V, 630, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(V, 700, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(V, 720, `OVL_ROW_TOP, `OVL_ROW_BOT),
        tseg(H, `OVL_ROW_TOP, 720, 790),
        tseg(H, `OVL_ROW_MID, 720, 790),
        tseg(H, `OVL_ROW_BOT, 720, 790),
        // subtitle, rows 300..380, no offset
        seg(H, 300, 100, 150),
        seg(V, 100, 300, 380),
        seg(H, 380, 100, 150),
        seg(H, 300, 170, 220),
        seg(H, 380, 170, 220),
        seg(V, 170, 300, 380),
        seg(V, 220, 300, 380),
        seg(V, 240, 300, 380),
        seg(H, 380, 240, 290),
        seg(H, 300, 310, 360),
        seg(H, 380, 310, 360),
        seg(V, 310, 300, 380),
        seg(V, 360, 300, 380),
        seg(V, 380, 300, 380),              // R, leg diagonal not drawn
        seg(V, 430, 300, 340),
        seg(H, 300, 380, 430),
        seg(H, 340, 380, 430),
        seg(H, 300, 500, 550),
        seg(H, 340, 500, 550),
        seg(H, 380, 500, 550),
        seg(V, 500, 300, 380),
        seg(V, 570, 300, 380),              // D, corner bevels dropped
        seg(H, 300, 570, 615),
        seg(H, 380, 570, 615),
        seg(V, 620, 305, 375),
        seg(V, 640, 300, 380),
        seg(H, 300, 660, 710),              // T top bar
        seg(V, 685, 300, 380),
        seg(V, 710, 300, 380),
        seg(V, 730, 300, 380),
        seg(H, 300, 730, 780),
        seg(V, 780, 300, 380),
        seg(H, 380, 730, 780),
        seg(V, 800, 300, 380),              // N, diagonal dropped
        seg(V, 850, 300, 380)
    };

    //////////////////////////////////////////////////
    // hit test
    //////////////////////////////////////////////////

    always_comb
    begin
        stroke_hit = 1'b0;
        for (int i = 0; i < N_STROKES; i++)
        begin
            if (STROKES[i].vert)
            begin
                if ((hcount == STROKES[i].fixed) &&
                    (vcount >= STROKES[i].first) && (vcount <= STROKES[i].last))
                    stroke_hit = 1'b1;
            end
            else if ((vcount == STROKES[i].fixed) &&
                     (hcount >= STROKES[i].first) && (hcount <= STROKES[i].last))
            begin
                stroke_hit = 1'b1;
            end
        end
    end

endmodule

// File: source/vga_overlay_top.sv
`timescale 1ns/1ps

module vga_overlay_top
    import overlay_pkg::*;
(
    input  logic         pclk,
    input  logic         rst,
    input  pixel_coord_t hcount_in,
    input  pixel_coord_t vcount_in,
    input  logic         hsync_in,
    input  logic         vsync_in,
    input  logic         hblnk_in,
    input  logic         vblnk_in,
    input  logic         start_en,
    input  logic         choice_en,
    input  logic [7:0]   char_pixels,  // from external char rom, same cycle
    output pixel_coord_t hcount_out,
    output pixel_coord_t vcount_out,
    output logic         hsync_out,
    output logic         vsync_out,
    output logic         hblnk_out,
    output logic         vblnk_out,
    output rgb12_t       rgb_out,
    output logic [7:0]   char_xy,      // to char rom
    output logic [3:0]   char_line
);

    screen_mode_t screen_mode;
    logic         text_hit;
    logic         glyph_on;
    logic         stroke_hit;

    // mode decode and text box addressing
    text_window u_text_window (
        .hcount      (hcount_in),
        .vcount      (vcount_in),
        .start_en    (start_en),
        .choice_en   (choice_en),
        .char_pixels (char_pixels),
        .screen_mode (screen_mode),
        .text_hit    (text_hit),
        .glyph_on    (glyph_on),
        .char_xy     (char_xy),
        .char_line   (char_line)
    );

    // red title lettering
    title_strokes u_title_strokes (
        .hcount     (hcount_in),
        .vcount     (vcount_in),
        .stroke_hit (stroke_hit)
    );

    overlay_pixel_stage u_pixel_stage (
        .pclk        (pclk),
        .rst         (rst),
        .hcount_in   (hcount_in),
        .vcount_in   (vcount_in),
        .hsync_in    (hsync_in),
        .vsync_in    (vsync_in),
        .hblnk_in    (hblnk_in),
        .vblnk_in    (vblnk_in),
        .screen_mode (screen_mode),
        .text_hit    (text_hit),
        .glyph_on    (glyph_on),
        .stroke_hit  (stroke_hit),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .hblnk_out   (hblnk_out),
        .vblnk_out   (vblnk_out),
        .rgb_out     (rgb_out)
    );

endmodule
